//--- Bender.yml
package:
  name: mips_exec_pipe

sources:
  - include_dirs:
      - common
    files:
      - common/mips_isa_pkg.sv
      - common/mips_pipe_pkg.sv
      - hdl/decode/mips_decode.sv
      - hdl/exec/mips_execute.sv
      - hdl/mem/mips_mem_access.sv
      - hdl/mips_exec_pipe.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - dv/mips_exec_pipe_assertions.sv
      - dv/tb_mips_exec_pipe.sv

//--- common/mips_isa_pkg.sv
/*
 * mips_isa_pkg: instruction set encodings
 * major opcodes, SPECIAL function codes and the two views of an instruction word
 */

`include "mips_params.svh"

package mips_isa_pkg;

   // major opcode, bits 31..26
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_SLTIU   = 6'h0b,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LB      = 6'h20,
      OP_LH      = 6'h21,
      OP_LW      = 6'h23,
      OP_LBU     = 6'h24,
      OP_LHU     = 6'h25,
      OP_SB      = 6'h28,
      OP_SH      = 6'h29,
      OP_SW      = 6'h2b
   } opcode_e;

   // function code of SPECIAL, bits 5..0
   typedef enum logic [5:0] {
      FN_SLL  = 6'h00,
      FN_SRL  = 6'h02,
      FN_SRA  = 6'h03,
      FN_SLLV = 6'h04,
      FN_SRLV = 6'h06,
      FN_SRAV = 6'h07,
      FN_ADDU = 6'h21,
      FN_SUBU = 6'h23,
      FN_AND  = 6'h24,
      FN_OR   = 6'h25,
      FN_XOR  = 6'h26,
      FN_NOR  = 6'h27,
      FN_SLT  = 6'h2a,
      FN_SLTU = 6'h2b
   } funct_e;

   // register format
   typedef struct packed {
      opcode_e                  opcode;
      logic [`MIPS_REG_W-1:0]   rs;
      logic [`MIPS_REG_W-1:0]   rt;
      logic [`MIPS_REG_W-1:0]   rd;
      logic [`MIPS_SHAMT_W-1:0] shamt;
      funct_e                   funct;
   } r_fmt_t;

   // immediate format
   typedef struct packed {
      opcode_e                opcode;
      logic [`MIPS_REG_W-1:0] rs;
      logic [`MIPS_REG_W-1:0] rt;
      logic [15:0]            imm;
   } i_fmt_t;

   // same word, read as either format
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_u;

endpackage

//--- common/mips_params.svh
/*
 * mips execute pipeline constants
 * widths of the datapath fields and the number of registered stages
 */

`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// datapath word width
`define MIPS_WORD_W 32

// register index width (32 architectural registers)
`define MIPS_REG_W 5

// byte lanes per word
`define MIPS_BE_W 4

// shift amount field width
`define MIPS_SHAMT_W 5

// registered stages from input capture to writeback output
`define MIPS_PIPE_DEPTH 3

`endif

//--- common/mips_pipe_pkg.sv
/*
 * mips_pipe_pkg: pipeline types
 * operation codes, decoded control and the bundles passed between stages
 */

`include "mips_params.svh"

package mips_pipe_pkg;

   // ALU function selected in decode
   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_SLL  = 4'd2,
      ALU_SRL  = 4'd3,
      ALU_SRA  = 4'd4,
      ALU_SLLV = 4'd5,
      ALU_SRLV = 4'd6,
      ALU_SRAV = 4'd7,
      ALU_AND  = 4'd8,
      ALU_OR   = 4'd9,
      ALU_XOR  = 4'd10,
      ALU_NOR  = 4'd11,
      ALU_SLT  = 4'd12,
      ALU_SLTU = 4'd13,
      ALU_LUI  = 4'd14
   } alu_op_e;

   // memory access kind, nine codes so four bits
   typedef enum logic [3:0] {
      MEM_NONE = 4'd0,
      MEM_LB   = 4'd1,
      MEM_LBU  = 4'd2,
      MEM_LH   = 4'd3,
      MEM_LHU  = 4'd4,
      MEM_LW   = 4'd5,
      MEM_SB   = 4'd6,
      MEM_SH   = 4'd7,
      MEM_SW   = 4'd8
   } mem_op_e;

   typedef struct packed {
      alu_op_e alu_op;
      mem_op_e mem_op;
      logic    use_imm;   // immediate replaces rt as operand b
      logic    sign_ext;  // sign extend the immediate, else zero extend
      logic    wr_en;
      logic    rsvd;      // reserved instruction
   } ctrl_t;

   // decode to execute
   typedef struct packed {
      logic                     valid;
      ctrl_t                    ctrl;
      logic [`MIPS_WORD_W-1:0]  op_a;
      logic [`MIPS_WORD_W-1:0]  op_b;
      logic [`MIPS_WORD_W-1:0]  imm;
      logic [`MIPS_SHAMT_W-1:0] shamt;
      logic [`MIPS_REG_W-1:0]   dst;
   } ex_stage_t;

   // execute to memory
   typedef struct packed {
      logic                    valid;
      mem_op_e                 mem_op;
      logic                    wr_en;
      logic                    rsvd;
      logic [`MIPS_WORD_W-1:0] alu_res;  // byte address for loads and stores
      logic [`MIPS_WORD_W-1:0] st_data;
      logic [`MIPS_REG_W-1:0]  dst;
   } mem_stage_t;

   // writeback output
   typedef struct packed {
      logic                    valid;
      logic                    wr_en;
      logic                    rsvd;
      logic [`MIPS_REG_W-1:0]  dst;
      logic [`MIPS_WORD_W-1:0] result;
   } wb_t;

endpackage

//--- dv/mips_exec_pipe_assertions.sv
/*
 * mips_exec_pipe_assertions: memory port and writeback protocol checks
 */

`timescale 1ns/1ps
`include "mips_params.svh"

module mips_exec_pipe_assertions
   import mips_pipe_pkg::*;
(
   input logic                  clk,
   input logic                  rst_b,
   input logic                  mem_req,
   input logic                  mem_we,
   input logic [`MIPS_BE_W-1:0] mem_be,
   input wb_t                   out
);

   // a write is always part of a request
   we_needs_req: assert property (@(posedge clk) disable iff (!rst_b)
      mem_we |-> mem_req)
      else $error("memory write without request");

   // stores must enable at least one lane
   store_has_lanes: assert property (@(posedge clk) disable iff (!rst_b)
      mem_we |-> (mem_be != '0))
      else $error("store with all byte enables low");

   // writeback only for a valid slot and never to $zero
   wr_is_legal: assert property (@(posedge clk) disable iff (!rst_b)
      out.wr_en |-> (out.valid && out.dst != '0))
      else $error("register write without valid slot or to register zero");

endmodule

//--- dv/tb_mips_exec_pipe.sv
/*
 * tb_mips_exec_pipe: testbench for the three-stage execute pipeline
 * directed table plus random ALU rows, memory model and in-order output check
 */

`timescale 1ns/1ps
`include "mips_params.svh"

module tb_mips_exec_pipe
   import mips_isa_pkg::*, mips_pipe_pkg::*;
();

   localparam int unsigned N_RAND = 40;
   localparam int unsigned SEED   = 74843;

   // one stimulus row and what the writeback port must show for it
   typedef struct {
      logic [`MIPS_WORD_W-1:0] inst;
      logic [`MIPS_WORD_W-1:0] rs;
      logic [`MIPS_WORD_W-1:0] rt;
      logic [`MIPS_WORD_W-1:0] res;
      logic [`MIPS_REG_W-1:0]  dst;
      logic                    wr;
      logic                    rsvd;
      int                      cap;
   } row_t;

   logic                    clk = 1'b0;
   logic                    rst_b;
   logic                    in_valid;
   logic [`MIPS_WORD_W-1:0] inst_w;
   logic [`MIPS_WORD_W-1:0] rs_data;
   logic [`MIPS_WORD_W-1:0] rt_data;
   logic                    mem_req;
   logic                    mem_we;
   logic [`MIPS_BE_W-1:0]   mem_be;
   logic [`MIPS_WORD_W-3:0] mem_addr;
   logic [`MIPS_WORD_W-1:0] mem_wdata;
   logic [`MIPS_WORD_W-1:0] mem_rdata;
   wb_t                     out_w;

   row_t                    rows[$];
   row_t                    exp_q[$];
   logic [`MIPS_WORD_W-1:0] mem_words [16];
   int                      cyc = 0;
   int                      limit = 0;
   int                      mismatch_cnt = 0;
   int                      other_cnt = 0;

   // kept SPECIAL functions that random rows draw from
   funct_e fn_list [14] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT,
                            FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};

   mips_exec_pipe dut_i (
      .clk       (clk),
      .rst_b     (rst_b),
      .in_valid  (in_valid),
      .inst      (inst_w),
      .rs_data   (rs_data),
      .rt_data   (rt_data),
      .mem_req   (mem_req),
      .mem_we    (mem_we),
      .mem_be    (mem_be),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata),
      .out       (out_w)
   );

   bind mips_exec_pipe mips_exec_pipe_assertions assertions_i (
      .clk     (clk),
      .rst_b   (rst_b),
      .mem_req (mem_req),
      .mem_we  (mem_we),
      .mem_be  (mem_be),
      .out     (out)
   );

   initial
   begin
      forever
         #2 clk = ~clk;
   end

   always @(posedge clk)
      cyc <= cyc + 1;

   // 16-word memory that answers in the same cycle only while requested
   assign mem_rdata = mem_req ? mem_words[mem_addr[3:0]] : '0;

   // byte-masked write
   always @(posedge clk)
   begin
      if (mem_we)
      begin
         for (int b = 0; b < `MIPS_BE_W; b++)
            if (mem_be[b])
               mem_words[mem_addr[3:0]][8*b +: 8] <= mem_wdata[8*b +: 8];
      end
   end

   // register format word with rs and rt fields left as don't-care
   function automatic logic [`MIPS_WORD_W-1:0] enc_r(input logic [5:0] fn,
                                                    input logic [4:0] rd,
                                                    input logic [4:0] sh);
      return {6'h00, 5'd1, 5'd2, rd, sh, fn};
   endfunction

   function automatic logic [`MIPS_WORD_W-1:0] enc_i(input logic [5:0] op,
                                                    input logic [4:0] rt,
                                                    input logic [15:0] imm);
      return {op, 5'd1, rt, imm};
   endfunction

   // R-type result as the instruction set defines it
   function automatic logic [`MIPS_WORD_W-1:0] alu_expect(input logic [5:0] fn,
                                                         input logic [31:0] a,
                                                         input logic [31:0] b,
                                                         input logic [4:0] sh);
      case (fn)
         FN_ADDU: return a + b;
         FN_SUBU: return a - b;
         FN_AND:  return a & b;
         FN_OR:   return a | b;
         FN_XOR:  return a ^ b;
         FN_NOR:  return ~(a | b);
         FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         FN_SLTU: return (a < b) ? 32'd1 : 32'd0;
         // shifts move rt and variable forms count by rs[4:0]
         FN_SLL:  return b << sh;
         FN_SRL:  return b >> sh;
         FN_SRA:  return $signed(b) >>> sh;
         FN_SLLV: return b << a[4:0];
         FN_SRLV: return b >> a[4:0];
         FN_SRAV: return $signed(b) >>> a[4:0];
         default: return '0;
      endcase
   endfunction

   task automatic add_row(input logic [31:0] inst, input logic [31:0] rs,
                          input logic [31:0] rt, input logic [31:0] res,
                          input logic [4:0] dst, input logic wr, input logic rsvd);
      row_t r;
      r.inst = inst;
      r.rs   = rs;
      r.rt   = rt;
      r.res  = res;
      r.dst  = dst;
      r.wr   = wr;
      r.rsvd = rsvd;
      r.cap  = 0;
      rows.push_back(r);
   endtask

   task automatic add_random_alu_rows(input int n);
      logic [5:0]  fn;
      logic [31:0] a;
      logic [31:0] b;
      logic [4:0]  rd;
      logic [4:0]  sh;
      for (int i = 0; i < n; i++)
      begin
         fn = fn_list[$urandom_range(13, 0)];
         a  = $urandom;
         b  = $urandom;
         rd = $urandom_range(31, 1);
         sh = $urandom_range(31, 0);
         add_row(enc_r(fn, rd, sh), a, b, alu_expect(fn, a, b, sh), rd, 1'b1, 1'b0);
      end
   endtask

   task automatic check_val(input string name, input logic [31:0] exp,
                            input logic [31:0] got);
      assert (got === exp)
      else
      begin
         $display("MISMATCH t=%0t %s exp=%h got=%h", $time, name, exp, got);
         mismatch_cnt++;
      end
   endtask

   task automatic build_table();
      // R-type ALU where -2 against 3 separates signed from unsigned compare
      add_row(enc_r(FN_ADDU, 5'd3, 0), 32'hFFFF_FFFE, 32'h3, 32'h0000_0001, 5'd3, 1, 0);
      add_row(enc_r(FN_SUBU, 5'd4, 0), 32'hFFFF_FFFE, 32'h3, 32'hFFFF_FFFB, 5'd4, 1, 0);
      add_row(enc_r(FN_AND, 5'd5, 0), 32'hFFFF_FFFE, 32'h3, 32'h0000_0002, 5'd5, 1, 0);
      add_row(enc_r(FN_OR, 5'd6, 0), 32'hFFFF_FFFE, 32'h3, 32'hFFFF_FFFF, 5'd6, 1, 0);
      add_row(enc_r(FN_XOR, 5'd7, 0), 32'hFFFF_FFFE, 32'h3, 32'hFFFF_FFFD, 5'd7, 1, 0);
      add_row(enc_r(FN_NOR, 5'd8, 0), 32'hFFFF_FFFE, 32'h3, 32'h0000_0000, 5'd8, 1, 0);
      add_row(enc_r(FN_SLT, 5'd9, 0), 32'hFFFF_FFFE, 32'h3, 32'h0000_0001, 5'd9, 1, 0);
      add_row(enc_r(FN_SLTU, 5'd10, 0), 32'hFFFF_FFFE, 32'h3, 32'h0, 5'd10, 1, 0);
      // fixed shifts by 4 and variable shifts by rs[4:0] = 8
      add_row(enc_r(FN_SLL, 5'd11, 4), 32'h0, 32'h8000_00F0, 32'h0000_0F00, 5'd11, 1, 0);
      add_row(enc_r(FN_SRL, 5'd12, 4), 32'h0, 32'h8000_00F0, 32'h0800_000F, 5'd12, 1, 0);
      add_row(enc_r(FN_SRA, 5'd13, 4), 32'h0, 32'h8000_00F0, 32'hF800_000F, 5'd13, 1, 0);
      add_row(enc_r(FN_SLLV, 5'd14, 0), 32'hFFFF_FFE8, 32'h8000_00F0, 32'h0000_F000,
              5'd14, 1, 0);
      add_row(enc_r(FN_SRLV, 5'd15, 0), 32'hFFFF_FFE8, 32'h8000_00F0, 32'h0080_0000,
              5'd15, 1, 0);
      add_row(enc_r(FN_SRAV, 5'd16, 0), 32'hFFFF_FFE8, 32'h8000_00F0, 32'hFF80_0000,
              5'd16, 1, 0);
      // immediate forms with sign versus zero extension
      add_row(enc_i(OP_ADDIU, 5'd17, 16'hFFFE), 32'h10, 32'h0, 32'h0000_000E, 5'd17, 1, 0);
      add_row(enc_i(OP_SLTI, 5'd18, 16'hFFFF), 32'h10, 32'h0, 32'h0, 5'd18, 1, 0);
      add_row(enc_i(OP_SLTI, 5'd19, 16'hFFFF), 32'hFFFF_FFF0, 32'h0, 32'h1, 5'd19, 1, 0);
      add_row(enc_i(OP_SLTIU, 5'd20, 16'hFFFF), 32'h10, 32'h0, 32'h1, 5'd20, 1, 0);
      add_row(enc_i(OP_ANDI, 5'd21, 16'h8001), 32'hFFFF_FFFF, 32'h0, 32'h0000_8001,
              5'd21, 1, 0);
      add_row(enc_i(OP_ORI, 5'd22, 16'h8001), 32'h1234_0000, 32'h0, 32'h1234_8001,
              5'd22, 1, 0);
      add_row(enc_i(OP_XORI, 5'd23, 16'h8001), 32'hFFFF_0000, 32'h0, 32'hFFFF_8001,
              5'd23, 1, 0);
      add_row(enc_i(OP_LUI, 5'd24, 16'h8765), 32'h5555_5555, 32'h0, 32'h8765_0000,
              5'd24, 1, 0);
      // loads from word 0 = 80F17F02 and word 1 = 12345678
      add_row(enc_i(OP_LB, 5'd1, 16'h0), 32'h0, 32'h0, 32'h0000_0002, 5'd1, 1, 0);
      add_row(enc_i(OP_LB, 5'd2, 16'h1), 32'h0, 32'h0, 32'h0000_007F, 5'd2, 1, 0);
      add_row(enc_i(OP_LB, 5'd3, 16'h2), 32'h0, 32'h0, 32'hFFFF_FFF1, 5'd3, 1, 0);
      add_row(enc_i(OP_LB, 5'd4, 16'h3), 32'h0, 32'h0, 32'hFFFF_FF80, 5'd4, 1, 0);
      add_row(enc_i(OP_LBU, 5'd5, 16'h0), 32'h0, 32'h0, 32'h0000_0002, 5'd5, 1, 0);
      add_row(enc_i(OP_LBU, 5'd6, 16'h1), 32'h0, 32'h0, 32'h0000_007F, 5'd6, 1, 0);
      add_row(enc_i(OP_LBU, 5'd7, 16'h2), 32'h0, 32'h0, 32'h0000_00F1, 5'd7, 1, 0);
      add_row(enc_i(OP_LBU, 5'd8, 16'h3), 32'h0, 32'h0, 32'h0000_0080, 5'd8, 1, 0);
      add_row(enc_i(OP_LH, 5'd9, 16'h0), 32'h0, 32'h0, 32'h0000_7F02, 5'd9, 1, 0);
      add_row(enc_i(OP_LH, 5'd10, 16'h2), 32'h0, 32'h0, 32'hFFFF_80F1, 5'd10, 1, 0);
      add_row(enc_i(OP_LHU, 5'd11, 16'h0), 32'h0, 32'h0, 32'h0000_7F02, 5'd11, 1, 0);
      add_row(enc_i(OP_LHU, 5'd12, 16'h2), 32'h0, 32'h0, 32'h0000_80F1, 5'd12, 1, 0);
      add_row(enc_i(OP_LW, 5'd13, 16'h0), 32'h0, 32'h0, 32'h80F1_7F02, 5'd13, 1, 0);
      add_row(enc_i(OP_LB, 5'd14, 16'h1), 32'h4, 32'h0, 32'h0000_0056, 5'd14, 1, 0);
      add_row(enc_i(OP_LH, 5'd15, 16'h2), 32'h4, 32'h0, 32'h0000_1234, 5'd15, 1, 0);
      // byte stores into word 8 (11111111) one per lane and then read back
      add_row(enc_i(OP_SB, 5'd3, 16'h0), 32'h20, 32'hAABB_CC01, 32'h0, 5'd0, 0, 0);
      add_row(enc_i(OP_SB, 5'd3, 16'h1), 32'h20, 32'hAABB_CC02, 32'h0, 5'd0, 0, 0);
      add_row(enc_i(OP_SB, 5'd3, 16'h2), 32'h20, 32'hAABB_CC03, 32'h0, 5'd0, 0, 0);
      add_row(enc_i(OP_SB, 5'd3, 16'h3), 32'h20, 32'hAABB_CC04, 32'h0, 5'd0, 0, 0);
      add_row(enc_i(OP_LW, 5'd25, 16'h0), 32'h20, 32'h0, 32'h0403_0201, 5'd25, 1, 0);
      // half stores into word 9 (22222222) at lanes 0 and 2
      add_row(enc_i(OP_SH, 5'd3, 16'h4), 32'h20, 32'hDEAD_BEEF, 32'h0, 5'd0, 0, 0);
      add_row(enc_i(OP_SH, 5'd3, 16'h6), 32'h20, 32'h0000_CAFE, 32'h0, 5'd0, 0, 0);
      add_row(enc_i(OP_LW, 5'd26, 16'h4), 32'h20, 32'h0, 32'hCAFE_BEEF, 5'd26, 1, 0);
      // full word store into word 10
      add_row(enc_i(OP_SW, 5'd3, 16'h8), 32'h20, 32'h1357_9BDF, 32'h0, 5'd0, 0, 0);
      add_row(enc_i(OP_LW, 5'd27, 16'h8), 32'h20, 32'h0, 32'h1357_9BDF, 5'd27, 1, 0);
      // reserved opcodes and funct and then a write to $zero
      add_row(enc_i(6'h02, 5'd5, 16'h0), 32'h0, 32'h0, 32'h0, 5'd0, 0, 1);
      add_row(enc_i(6'h3F, 5'd5, 16'h0), 32'h0, 32'h0, 32'h0, 5'd0, 0, 1);
      add_row(enc_r(6'h18, 5'd5, 0), 32'h0, 32'h0, 32'h0, 5'd0, 0, 1);
      add_row(enc_r(FN_ADDU, 5'd0, 0), 32'h1, 32'h2, 32'h0, 5'd0, 0, 0);
   endtask

   // outputs settle after the rising edge so compare on the falling edge
   always @(negedge clk)
   begin
      row_t e;
      if (!rst_b)
      begin
         assert (!out_w.valid && !out_w.wr_en && !mem_req && !mem_we)
         else
         begin
            $display("t=%0t outputs not cleared during reset", $time);
            other_cnt++;
         end
      end
      else if (out_w.valid)
      begin
         assert (exp_q.size() != 0)
         else
         begin
            $display("t=%0t output valid with no instruction in flight", $time);
            other_cnt++;
         end
         if (exp_q.size() != 0)
         begin
            e = exp_q.pop_front();
            // two edges after the capture edge
            assert (cyc == e.cap + `MIPS_PIPE_DEPTH - 1)
            else
            begin
               $display("t=%0t output at cycle %0d, expected at cycle %0d", $time, cyc,
                        e.cap + `MIPS_PIPE_DEPTH - 1);
               other_cnt++;
            end
            check_val("out.wr_en", e.wr, out_w.wr_en);
            check_val("out.rsvd", e.rsvd, out_w.rsvd);
            if (e.wr)
            begin
               check_val("out.dst", e.dst, out_w.dst);
               check_val("out.result", e.res, out_w.result);
            end
         end
      end
   end

   // watchdog sized from the row count
   initial
   begin
      @(posedge clk);
      while (cyc < limit)
         @(posedge clk);
      $display("timeout after %0d cycles, outputs still outstanding: %0d", cyc,
               exp_q.size());
      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
      $display("TEST FAIL");
      $finish;
   end

   initial
   begin
      row_t e;
      void'($urandom(SEED));
      rst_b    = 1'b0;
      in_valid = 1'b0;
      inst_w   = '0;
      rs_data  = '0;
      rt_data  = '0;
      mem_words = '{32'h80F1_7F02, 32'h1234_5678, 32'hFFEE_DDCC, 32'h0011_2233,
                    32'hA5A5_0004, 32'hA5A5_0005, 32'hA5A5_0006, 32'hA5A5_0007,
                    32'h1111_1111, 32'h2222_2222, 32'h3333_3333, 32'hA5A5_000B,
                    32'hA5A5_000C, 32'hA5A5_000D, 32'hA5A5_000E, 32'hA5A5_000F};
      build_table();
      add_random_alu_rows(N_RAND);
      // rows already hold the random ones
      limit = rows.size() + `MIPS_PIPE_DEPTH + 20;

      repeat (3)
         @(posedge clk);
      @(negedge clk);
      rst_b = 1'b1;
      // one idle cycle where nothing may come out
      @(negedge clk);

      foreach (rows[i])
      begin
         in_valid = 1'b1;
         inst_w   = rows[i].inst;
         rs_data  = rows[i].rs;
         rt_data  = rows[i].rt;
         e        = rows[i];
         e.cap    = cyc + 1;
         exp_q.push_back(e);
         @(negedge clk);
      end
      in_valid = 1'b0;
      inst_w   = '0;

      while (exp_q.size() != 0)
         @(negedge clk);
      // trailing idle cycles catch stray valids
      repeat (4)
         @(negedge clk);

      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
      if (mismatch_cnt == 0 && other_cnt == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

//--- hdl/decode/mips_decode.sv
/*
 * mips_decode: instruction decoder and decode-stage register
 * builds the execute bundle from one instruction word and its rs/rt values
 */

`timescale 1ns/1ps
`include "mips_params.svh"

module mips_decode
   import mips_isa_pkg::*, mips_pipe_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_b,
   input  logic                    in_valid,
   input  instr_u                  inst,
   input  logic [`MIPS_WORD_W-1:0] rs_data,
   input  logic [`MIPS_WORD_W-1:0] rt_data,
   output ex_stage_t               ex
);

   localparam int unsigned IMM_W = 16;

   ctrl_t                    ctrl;
   logic                     r_type;
   logic                     is_store;
   logic [`MIPS_REG_W-1:0]   dst;
   logic [`MIPS_WORD_W-1:0]  imm_ext;

   logic                     valid_q;
   ctrl_t                    ctrl_q;
   logic [`MIPS_WORD_W-1:0]  op_a_q;
   logic [`MIPS_WORD_W-1:0]  op_b_q;
   logic [`MIPS_WORD_W-1:0]  imm_q;
   logic [`MIPS_SHAMT_W-1:0] shamt_q;
   logic [`MIPS_REG_W-1:0]   dst_q;

   // rd for SPECIAL, rt for every immediate form
   assign r_type = (inst.r.opcode == OP_SPECIAL);
   assign dst    = r_type ? inst.r.rd : inst.i.rt;

   assign imm_ext = ctrl.sign_ext ?
                    {{(`MIPS_WORD_W-IMM_W){inst.i.imm[IMM_W-1]}}, inst.i.imm} :
                    {{(`MIPS_WORD_W-IMM_W){1'b0}}, inst.i.imm};

   assign is_store = inst.r.opcode inside {OP_SB, OP_SH, OP_SW};

   always_comb
   begin
      // immediate add by default, which also forms load/store addresses
      ctrl.alu_op   = ALU_ADD;
      ctrl.mem_op   = MEM_NONE;
      ctrl.use_imm  = 1'b1;
      ctrl.sign_ext = 1'b1;
      ctrl.wr_en    = 1'b1;
      ctrl.rsvd     = 1'b0;
      case (inst.r.opcode)
         OP_SPECIAL:
         begin
            ctrl.use_imm = 1'b0;
            case (inst.r.funct)
               FN_ADDU: ctrl.alu_op = ALU_ADD;
               FN_SUBU: ctrl.alu_op = ALU_SUB;
               FN_AND:  ctrl.alu_op = ALU_AND;
               FN_OR:   ctrl.alu_op = ALU_OR;
               FN_XOR:  ctrl.alu_op = ALU_XOR;
               FN_NOR:  ctrl.alu_op = ALU_NOR;
               FN_SLT:  ctrl.alu_op = ALU_SLT;
               FN_SLTU: ctrl.alu_op = ALU_SLTU;
               FN_SLL:  ctrl.alu_op = ALU_SLL;
               FN_SRL:  ctrl.alu_op = ALU_SRL;
               FN_SRA:  ctrl.alu_op = ALU_SRA;
               FN_SLLV: ctrl.alu_op = ALU_SLLV;
               FN_SRLV: ctrl.alu_op = ALU_SRLV;
               FN_SRAV: ctrl.alu_op = ALU_SRAV;
               default: ctrl.rsvd   = 1'b1;
            endcase
         end
         OP_ADDIU: ctrl.alu_op = ALU_ADD;
         OP_SLTI:  ctrl.alu_op = ALU_SLT;
         // sltiu sign extends too and only the compare is unsigned
         OP_SLTIU: ctrl.alu_op = ALU_SLTU;
         OP_ANDI:
         begin
            ctrl.alu_op   = ALU_AND;
            ctrl.sign_ext = 1'b0;
         end
         OP_ORI:
         begin
            ctrl.alu_op   = ALU_OR;
            ctrl.sign_ext = 1'b0;
         end
         OP_XORI:
         begin
            ctrl.alu_op   = ALU_XOR;
            ctrl.sign_ext = 1'b0;
         end
         OP_LUI:
         begin
            ctrl.alu_op   = ALU_LUI;
            ctrl.sign_ext = 1'b0;
         end
         OP_LB:   ctrl.mem_op = MEM_LB;
         OP_LBU:  ctrl.mem_op = MEM_LBU;
         OP_LH:   ctrl.mem_op = MEM_LH;
         OP_LHU:  ctrl.mem_op = MEM_LHU;
         OP_LW:   ctrl.mem_op = MEM_LW;
         OP_SB:   ctrl.mem_op = MEM_SB;
         OP_SH:   ctrl.mem_op = MEM_SH;
         OP_SW:   ctrl.mem_op = MEM_SW;
         default: ctrl.rsvd   = 1'b1;
      endcase
      // no write for empty slots, stores, reserved codes or $zero
      if (!in_valid || ctrl.rsvd || is_store || dst == '0)
         ctrl.wr_en = 1'b0;
      if (!in_valid)
         ctrl.rsvd = 1'b0;
   end

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         valid_q <= 1'b0;
         ctrl_q  <= '0;
      end
      else
      begin
         valid_q <= in_valid;
         ctrl_q  <= ctrl;
      end
   end

   // operands and fields
   always_ff @(posedge clk)
   begin
      op_a_q  <= rs_data;
      op_b_q  <= rt_data;
      imm_q   <= imm_ext;
      shamt_q <= inst.r.shamt;
      dst_q   <= dst;
   end

   assign ex = '{valid: valid_q, ctrl: ctrl_q, op_a: op_a_q, op_b: op_b_q,
                 imm: imm_q, shamt: shamt_q, dst: dst_q};

endmodule

//--- hdl/exec/mips_execute.sv
/*
 * mips_execute: ALU and execute-stage register
 */

`timescale 1ns/1ps
`include "mips_params.svh"

module mips_execute
   import mips_pipe_pkg::*;
(
   input  logic       clk,
   input  logic       rst_b,
   input  ex_stage_t  ex,
   output mem_stage_t mem
);

   localparam int unsigned HALF_W = `MIPS_WORD_W / 2;

   logic [`MIPS_WORD_W-1:0]  opnd_b;
   logic [`MIPS_SHAMT_W-1:0] var_sh;
   logic [`MIPS_WORD_W-1:0]  alu_res;

   logic                     valid_q;
   mem_op_e                  mem_op_q;
   logic                     wr_en_q;
   logic                     rsvd_q;
   logic [`MIPS_WORD_W-1:0]  alu_res_q;
   logic [`MIPS_WORD_W-1:0]  st_data_q;
   logic [`MIPS_REG_W-1:0]   dst_q;

   // rt or the extended immediate
   assign opnd_b = ex.ctrl.use_imm ? ex.imm : ex.op_b;

   // variable shifts take their count from the low bits of rs
   assign var_sh = ex.op_a[`MIPS_SHAMT_W-1:0];

   always_comb
   begin
      case (ex.ctrl.alu_op)
         ALU_ADD:  alu_res = ex.op_a + opnd_b;
         ALU_SUB:  alu_res = ex.op_a - opnd_b;
         // shifts always move rt
         ALU_SLL:  alu_res = opnd_b << ex.shamt;
         ALU_SRL:  alu_res = opnd_b >> ex.shamt;
         ALU_SRA:  alu_res = $signed(opnd_b) >>> ex.shamt;
         ALU_SLLV: alu_res = opnd_b << var_sh;
         ALU_SRLV: alu_res = opnd_b >> var_sh;
         ALU_SRAV: alu_res = $signed(opnd_b) >>> var_sh;
         ALU_AND:  alu_res = ex.op_a & opnd_b;
         ALU_OR:   alu_res = ex.op_a | opnd_b;
         ALU_XOR:  alu_res = ex.op_a ^ opnd_b;
         ALU_NOR:  alu_res = ~(ex.op_a | opnd_b);
         ALU_SLT:  alu_res = `MIPS_WORD_W'($signed(ex.op_a) < $signed(opnd_b));
         ALU_SLTU: alu_res = `MIPS_WORD_W'(ex.op_a < opnd_b);
         // immediate into the upper half, low half cleared
         ALU_LUI:  alu_res = {ex.imm[HALF_W-1:0], {HALF_W{1'b0}}};
         default:  alu_res = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         valid_q  <= 1'b0;
         mem_op_q <= MEM_NONE;
         wr_en_q  <= 1'b0;
         rsvd_q   <= 1'b0;
      end
      else
      begin
         valid_q  <= ex.valid;
         mem_op_q <= ex.ctrl.mem_op;
         wr_en_q  <= ex.ctrl.wr_en;
         rsvd_q   <= ex.ctrl.rsvd;
      end
   end

   // result, store source and destination
   always_ff @(posedge clk)
   begin
      alu_res_q <= alu_res;
      st_data_q <= ex.op_b;
      dst_q     <= ex.dst;
   end

   assign mem = '{valid: valid_q, mem_op: mem_op_q, wr_en: wr_en_q, rsvd: rsvd_q,
                  alu_res: alu_res_q, st_data: st_data_q, dst: dst_q};

endmodule

//--- hdl/mem/mips_mem_access.sv
/*
 * mips_mem_access: memory port driver, load alignment and writeback register
 * little-endian byte lanes, memory answers in the same cycle
 */

`timescale 1ns/1ps
`include "mips_params.svh"

module mips_mem_access
   import mips_pipe_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_b,
   input  mem_stage_t              mem,
   output logic                    mem_req,
   output logic                    mem_we,
   output logic [`MIPS_BE_W-1:0]   mem_be,
   output logic [`MIPS_WORD_W-3:0] mem_addr,
   output logic [`MIPS_WORD_W-1:0] mem_wdata,
   input  logic [`MIPS_WORD_W-1:0] mem_rdata,
   output wb_t                     wb
);

   logic                     is_load;
   logic                     is_store;
   logic                     is_half;
   logic [1:0]               lane_off;
   logic [`MIPS_SHAMT_W-1:0] bit_off;
   logic [`MIPS_BE_W-1:0]    be;
   logic [`MIPS_WORD_W-1:0]  ld_shift;
   logic [`MIPS_WORD_W-1:0]  result;

   logic                     valid_q;
   logic                     wr_en_q;
   logic                     rsvd_q;
   logic [`MIPS_REG_W-1:0]   dst_q;
   logic [`MIPS_WORD_W-1:0]  result_q;

   assign is_load  = mem.mem_op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
   assign is_store = mem.mem_op inside {MEM_SB, MEM_SH, MEM_SW};
   assign is_half  = mem.mem_op inside {MEM_LH, MEM_LHU, MEM_SH};

   // halves sit in lane 0 or 2, bytes in any lane
   assign lane_off = is_half ? {mem.alu_res[1], 1'b0} : mem.alu_res[1:0];
   assign bit_off  = {lane_off, 3'b000};

   assign mem_req  = mem.valid & (is_load | is_store);
   assign mem_we   = mem.valid & is_store;
   assign mem_addr = mem.alu_res[`MIPS_WORD_W-1:2];
   // loads keep every enable low
   assign mem_be   = mem_we ? be : '0;

   // store data moved up to its lane
   always_comb
   begin
      case (mem.mem_op)
         MEM_SB:
         begin
            be        = `MIPS_BE_W'(1) << lane_off;
            mem_wdata = `MIPS_WORD_W'(mem.st_data[7:0]) << bit_off;
         end
         MEM_SH:
         begin
            be        = `MIPS_BE_W'(3) << lane_off;
            mem_wdata = `MIPS_WORD_W'(mem.st_data[15:0]) << bit_off;
         end
         MEM_SW:
         begin
            be        = '1;
            mem_wdata = mem.st_data;
         end
         default:
         begin
            be        = '0;
            mem_wdata = mem.st_data;
         end
      endcase
   end

   // read word moved down from its lane, then extended
   assign ld_shift = mem_rdata >> bit_off;

   always_comb
   begin
      case (mem.mem_op)
         MEM_LB:  result = {{(`MIPS_WORD_W-8){ld_shift[7]}}, ld_shift[7:0]};
         MEM_LBU: result = {{(`MIPS_WORD_W-8){1'b0}}, ld_shift[7:0]};
         MEM_LH:  result = {{(`MIPS_WORD_W-16){ld_shift[15]}}, ld_shift[15:0]};
         MEM_LHU: result = {{(`MIPS_WORD_W-16){1'b0}}, ld_shift[15:0]};
         MEM_LW:  result = mem_rdata;
         default: result = mem.alu_res;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         valid_q <= 1'b0;
         wr_en_q <= 1'b0;
         rsvd_q  <= 1'b0;
      end
      else
      begin
         valid_q <= mem.valid;
         wr_en_q <= mem.wr_en;
         rsvd_q  <= mem.rsvd;
      end
   end

   always_ff @(posedge clk)
   begin
      dst_q    <= mem.dst;
      result_q <= result;
   end

   assign wb = '{valid: valid_q, wr_en: wr_en_q, rsvd: rsvd_q, dst: dst_q, result: result_q};

endmodule

//--- hdl/mips_exec_pipe.sv
/*
 * mips_exec_pipe: three-stage integer execute pipeline
 * decode, execute and memory access chained back to back, no back-pressure
 */

`timescale 1ns/1ps
`include "mips_params.svh"

module mips_exec_pipe
   import mips_isa_pkg::*, mips_pipe_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_b,
   input  logic                    in_valid,
   input  instr_u                  inst,
   input  logic [`MIPS_WORD_W-1:0] rs_data,
   input  logic [`MIPS_WORD_W-1:0] rt_data,
   output logic                    mem_req,
   output logic                    mem_we,
   output logic [`MIPS_BE_W-1:0]   mem_be,
   output logic [`MIPS_WORD_W-3:0] mem_addr,
   output logic [`MIPS_WORD_W-1:0] mem_wdata,
   input  logic [`MIPS_WORD_W-1:0] mem_rdata,
   output wb_t                     out
);

   // one registered stage per instance below
   localparam int unsigned N_STAGES = 3;

   ex_stage_t  ex;
   mem_stage_t mem;

   if (N_STAGES != `MIPS_PIPE_DEPTH)
   begin : g_depth_chk
      $error("pipeline depth mismatch");
   end

   mips_decode decode_i (
      .clk      (clk),
      .rst_b    (rst_b),
      .in_valid (in_valid),
      .inst     (inst),
      .rs_data  (rs_data),
      .rt_data  (rt_data),
      .ex       (ex)
   );

   mips_execute execute_i (
      .clk   (clk),
      .rst_b (rst_b),
      .ex    (ex),
      .mem   (mem)
   );

   // owns the memory port
   mips_mem_access mem_access_i (
      .clk       (clk),
      .rst_b     (rst_b),
      .mem       (mem),
      .mem_req   (mem_req),
      .mem_we    (mem_we),
      .mem_be    (mem_be),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata),
      .wb        (out)
   );

endmodule

//--- src.f
+incdir+common
common/mips_isa_pkg.sv
common/mips_pipe_pkg.sv
hdl/decode/mips_decode.sv
hdl/exec/mips_execute.sv
hdl/mem/mips_mem_access.sv
hdl/mips_exec_pipe.sv
dv/mips_exec_pipe_assertions.sv
dv/tb_mips_exec_pipe.sv
